// File: rtl/fetch_pkg.sv
package fetch_pkg;

    // byte address on the fetch path
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] instr_t;

    // one read beat with two instructions
    // low half at the 8-aligned address and high half at +4
    typedef logic [63:0] bus_data_t;

    // axi read response code
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // pc halts after an address-error fetch until a redirect
    typedef enum logic {
        PC_RUN,
        PC_HALT
    } pc_state_e;

endpackage

// File: rtl/pc_select.sv
`timescale 1ns/1ns

module pc_select #(
    parameter fetch_pkg::addr_t RESET_PC   = 32'hbfc0_0000,
    parameter fetch_pkg::addr_t EXC_VECTOR = 32'hbfc0_0380
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             i_exc,
    input  logic             i_eret,
    input  fetch_pkg::addr_t i_epc,
    input  logic             i_branch,
    input  fetch_pkg::addr_t i_branch_target,
    input  logic             i_fetch_ready,
    output logic             o_fetch_valid,
    output fetch_pkg::addr_t o_fetch_pc,
    output logic             o_fetch_single,
    output logic             o_fetch_adel,
    output logic             o_flush
);
    import fetch_pkg::*;

    pc_state_e state;
    addr_t     pc;
    addr_t     redirect_pc;
    logic      fetch_fire;

    // any redirect flushes everything downstream
    assign o_flush = i_exc | i_eret | i_branch;

    // exception wins over eret, which wins over branch
    always_comb begin
        if (i_exc) begin
            redirect_pc = EXC_VECTOR;
        end else if (i_eret) begin
            redirect_pc = i_epc;
        end else begin
            redirect_pc = i_branch_target;
        end
    end

    assign o_fetch_pc     = pc;
    // misaligned word gets no bus request
    assign o_fetch_adel   = pc[1:0] != 2'b00;
    // upper half only when bit 2 is set
    assign o_fetch_single = pc[2];
    // nothing offered while a redirect is being taken
    assign o_fetch_valid  = (state == PC_RUN) && !o_flush;
    assign fetch_fire     = o_fetch_valid && i_fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= PC_RUN;
            pc    <= RESET_PC;
        end else if (o_flush) begin
            state <= PC_RUN;
            pc    <= redirect_pc;
        end else if (fetch_fire) begin
            if (o_fetch_adel) begin
                // park here until someone steers us away
                state <= PC_HALT;
            end else begin
                pc <= pc + (o_fetch_single ? 32'd4 : 32'd8);
            end
        end
    end

    // offered fetch address holds until accepted
    a_pc_stable: assert property (@(posedge clk) disable iff (reset)
        o_fetch_valid && !i_fetch_ready |=> $stable(o_fetch_pc));

endmodule

// File: rtl/ifetch_req.sv
`timescale 1ns/1ns

module ifetch_req #(
    parameter int MAX_INFLIGHT = 2,
    parameter int QUEUE_DEPTH  = 2
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               i_flush,
    input  logic                               i_fetch_valid,
    input  fetch_pkg::addr_t                   i_fetch_pc,
    input  logic                               i_fetch_single,
    input  logic                               i_fetch_adel,
    output logic                               o_fetch_ready,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   i_free,
    output fetch_pkg::addr_t                   o_araddr,
    output logic                               o_arvalid,
    input  logic                               i_arready,
    input  fetch_pkg::bus_data_t               i_rdata,
    input  fetch_pkg::axi_resp_t               i_rresp,
    input  logic                               i_rvalid,
    output logic                               o_rready,
    output logic                               o_beat_valid,
    output fetch_pkg::addr_t                   o_beat_pc,
    output fetch_pkg::bus_data_t               o_beat_data,
    output logic                               o_beat_single,
    output logic                               o_beat_adel,
    output logic                               o_beat_err
);
    import fetch_pkg::*;

    localparam int PTR_W = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
    localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

    // in-order table of fetches in flight
    addr_t            ent_pc     [MAX_INFLIGHT];
    logic             ent_single [MAX_INFLIGHT];
    logic             ent_adel   [MAX_INFLIGHT];
    logic             ent_epoch  [MAX_INFLIGHT];
    logic             ent_sent   [MAX_INFLIGHT];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             epoch;
    logic             adel_pending;
    logic             push;
    logic             pop;
    logic             head_fresh;
    logic             credit_ok;

    // every reserved entry already has room in the pair queue
    assign o_rready = 1'b1;

    // queue space minus table entries minus the beat in the output register
    assign credit_ok = (32'(count) + 32'(o_beat_valid)) < 32'(i_free);

    // no new fetch behind an unsent adel entry as its pop would collide with a response
    assign o_fetch_ready = (count != CNT_W'(MAX_INFLIGHT)) && credit_ok
                         && (!o_arvalid || i_arready) && !adel_pending;
    assign push = i_fetch_valid && o_fetch_ready;

    // adel entries leave the table without a bus response
    assign pop        = (count != '0) && (ent_sent[head] ? i_rvalid : 1'b1);
    assign head_fresh = ent_epoch[head] == epoch;

    always_ff @(posedge clk) begin
        // older entries all become stale on a redirect
        if (i_flush) begin
            for (int i = 0; i < MAX_INFLIGHT; i++) begin
                ent_epoch[i] <= epoch;
            end
        end
        if (push) begin
            ent_pc[tail]     <= i_fetch_pc;
            ent_single[tail] <= i_fetch_single;
            ent_adel[tail]   <= i_fetch_adel;
            ent_epoch[tail]  <= epoch;
            ent_sent[tail]   <= !i_fetch_adel;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            epoch        <= 1'b0;
            adel_pending <= 1'b0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(MAX_INFLIGHT - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(MAX_INFLIGHT - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (i_flush) begin
                epoch <= !epoch;
            end
            if (pop && !ent_sent[head]) begin
                adel_pending <= 1'b0;
            end else if (push && i_fetch_adel) begin
                adel_pending <= 1'b1;
            end
        end
    end

    // ar address held until arready
    always_ff @(posedge clk) begin
        if (reset) begin
            o_arvalid <= 1'b0;
        end else if (push && !i_fetch_adel) begin
            o_arvalid <= 1'b1;
        end else if (i_arready) begin
            o_arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !i_fetch_adel) begin
            o_araddr <= {i_fetch_pc[31:3], 3'b000};
        end
    end

    // stale heads are consumed silently
    always_ff @(posedge clk) begin
        if (reset) begin
            o_beat_valid <= 1'b0;
        end else begin
            o_beat_valid <= pop && head_fresh && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            o_beat_pc     <= ent_pc[head];
            o_beat_data   <= i_rdata;
            o_beat_single <= ent_single[head];
            o_beat_adel   <= ent_adel[head];
            o_beat_err    <= ent_sent[head] && (i_rresp != RESP_OKAY);
        end
    end

    // memory answers only what was issued and in order
    a_resp_has_owner: assert property (@(posedge clk) disable iff (reset)
        i_rvalid |-> (count != '0) && ent_sent[head]);

endmodule

// File: rtl/fetch_split.sv
`timescale 1ns/1ns

module fetch_split #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_flush,
    input  logic                             i_beat_valid,
    input  fetch_pkg::addr_t                 i_beat_pc,
    input  fetch_pkg::bus_data_t             i_beat_data,
    input  logic                             i_beat_single,
    input  logic                             i_beat_adel,
    input  logic                             i_beat_err,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] o_free,
    input  logic                             i_pair_ready,
    output logic                             o_pair_valid,
    output fetch_pkg::addr_t                 o_pc,
    output fetch_pkg::instr_t                o_instr0,
    output fetch_pkg::instr_t                o_instr1,
    output logic                             o_slot1_valid,
    output logic                             o_adel,
    output logic                             o_bus_err
);
    import fetch_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // pair storage
    addr_t            q_pc     [QUEUE_DEPTH];
    instr_t           q_instr0 [QUEUE_DEPTH];
    instr_t           q_instr1 [QUEUE_DEPTH];
    logic             q_slot1  [QUEUE_DEPTH];
    logic             q_adel   [QUEUE_DEPTH];
    logic             q_err    [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;
    instr_t           split0;
    instr_t           split1;

    // bus word into slots
    always_comb begin
        split0 = i_beat_single ? i_beat_data[63:32] : i_beat_data[31:0];
        split1 = i_beat_data[63:32];
        if (i_beat_adel) begin
            // nothing fetched so no instructions to hand out
            split0 = '0;
            split1 = '0;
        end else if (i_beat_single) begin
            split1 = '0;
        end
    end

    assign wr_en  = i_beat_valid && !i_flush;
    assign rd_en  = o_pair_valid && i_pair_ready;
    assign o_free = CNT_W'(QUEUE_DEPTH) - count;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            q_pc[wr_ptr]     <= i_beat_pc;
            q_instr0[wr_ptr] <= split0;
            q_instr1[wr_ptr] <= split1;
            q_slot1[wr_ptr]  <= !i_beat_single && !i_beat_adel;
            q_adel[wr_ptr]   <= i_beat_adel;
            q_err[wr_ptr]    <= i_beat_err;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    // head entry stays put while the consumer stalls
    assign o_pair_valid  = count != '0;
    assign o_pc          = q_pc[rd_ptr];
    assign o_instr0      = q_instr0[rd_ptr];
    assign o_instr1      = q_instr1[rd_ptr];
    assign o_slot1_valid = q_slot1[rd_ptr];
    assign o_adel        = q_adel[rd_ptr];
    assign o_bus_err     = q_err[rd_ptr];

    // request side reserves space before it issues
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> count != CNT_W'(QUEUE_DEPTH));

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC     = 32'hbfc0_0000,
    parameter fetch_pkg::addr_t EXC_VECTOR   = 32'hbfc0_0380,
    parameter int               MAX_INFLIGHT = 2,
    parameter int               QUEUE_DEPTH  = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_exc,
    input  logic                 i_eret,
    input  fetch_pkg::addr_t     i_epc,
    input  logic                 i_branch,
    input  fetch_pkg::addr_t     i_branch_target,
    output fetch_pkg::addr_t     o_araddr,
    output logic                 o_arvalid,
    input  logic                 i_arready,
    input  fetch_pkg::bus_data_t i_rdata,
    input  fetch_pkg::axi_resp_t i_rresp,
    input  logic                 i_rvalid,
    output logic                 o_rready,
    input  logic                 i_pair_ready,
    output logic                 o_pair_valid,
    output fetch_pkg::addr_t     o_pc,
    output fetch_pkg::instr_t    o_instr0,
    output fetch_pkg::instr_t    o_instr1,
    output logic                 o_slot1_valid,
    output logic                 o_adel,
    output logic                 o_bus_err
);
    import fetch_pkg::*;

    // pc stage to request stage
    logic      flush;
    logic      fetch_valid;
    logic      fetch_ready;
    addr_t     fetch_pc;
    logic      fetch_single;
    logic      fetch_adel;
    // request stage to pair queue
    logic [$clog2(QUEUE_DEPTH+1)-1:0] free_cnt;
    logic      beat_valid;
    addr_t     beat_pc;
    bus_data_t beat_data;
    logic      beat_single;
    logic      beat_adel;
    logic      beat_err;

    pc_select #(
        .RESET_PC   (RESET_PC),
        .EXC_VECTOR (EXC_VECTOR)
    ) u_pc_select (
        .clk             (clk),
        .reset           (reset),
        .i_exc           (i_exc),
        .i_eret          (i_eret),
        .i_epc           (i_epc),
        .i_branch        (i_branch),
        .i_branch_target (i_branch_target),
        .i_fetch_ready   (fetch_ready),
        .o_fetch_valid   (fetch_valid),
        .o_fetch_pc      (fetch_pc),
        .o_fetch_single  (fetch_single),
        .o_fetch_adel    (fetch_adel),
        .o_flush         (flush)
    );

    ifetch_req #(
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) u_ifetch_req (
        .clk            (clk),
        .reset          (reset),
        .i_flush        (flush),
        .i_fetch_valid  (fetch_valid),
        .i_fetch_pc     (fetch_pc),
        .i_fetch_single (fetch_single),
        .i_fetch_adel   (fetch_adel),
        .o_fetch_ready  (fetch_ready),
        .i_free         (free_cnt),
        .o_araddr       (o_araddr),
        .o_arvalid      (o_arvalid),
        .i_arready      (i_arready),
        .i_rdata        (i_rdata),
        .i_rresp        (i_rresp),
        .i_rvalid       (i_rvalid),
        .o_rready       (o_rready),
        .o_beat_valid   (beat_valid),
        .o_beat_pc      (beat_pc),
        .o_beat_data    (beat_data),
        .o_beat_single  (beat_single),
        .o_beat_adel    (beat_adel),
        .o_beat_err     (beat_err)
    );

    fetch_split #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_split (
        .clk           (clk),
        .reset         (reset),
        .i_flush       (flush),
        .i_beat_valid  (beat_valid),
        .i_beat_pc     (beat_pc),
        .i_beat_data   (beat_data),
        .i_beat_single (beat_single),
        .i_beat_adel   (beat_adel),
        .i_beat_err    (beat_err),
        .o_free        (free_cnt),
        .i_pair_ready  (i_pair_ready),
        .o_pair_valid  (o_pair_valid),
        .o_pc          (o_pc),
        .o_instr0      (o_instr0),
        .o_instr1      (o_instr1),
        .o_slot1_valid (o_slot1_valid),
        .o_adel        (o_adel),
        .o_bus_err     (o_bus_err)
    );

endmodule

// File: sim/tb_fetch_tests.svh
`ifndef TB_FETCH_TESTS_SVH
`define TB_FETCH_TESTS_SVH

// memory content at byte address a
function automatic instr_t mem_word(input addr_t a);
    return a ^ MEM_KEY;
endfunction

// a single-slot fetch only moves four bytes on
function automatic addr_t next_pc(input addr_t p);
    return p + (p[2] ? 32'd4 : 32'd8);
endfunction

task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        value_errors++;
    end
endtask

task automatic check_instr(input string what, input instr_t got, input instr_t exp);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        value_errors++;
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        value_errors++;
    end
endtask

// waits for a pair handshake and returns with the pair outputs stable
task automatic take_pair(input bit random_ready);
    bit got;
    got = 1'b0;
    while (!got) begin
        @(negedge clk);
        i_pair_ready = random_ready ? 1'($urandom % 2) : 1'b1;
        got = o_pair_valid && i_pair_ready;
    end
endtask

// n pairs in a row from start checked against the memory rule
task automatic expect_pairs(input addr_t start, input int n, input bit random_ready);
    addr_t p;
    logic  err;
    p = start;
    for (int k = 0; k < n; k++) begin
        take_pair(random_ready);
        // bad address is marked by its 8-aligned bus address
        err = {p[31:3], 3'b000} == bad_addr;
        check_addr("pair pc", o_pc, p);
        check_flag("address error", o_adel, 1'b0);
        check_flag("bus error", o_bus_err, err);
        check_flag("slot 1 valid", o_slot1_valid, !p[2]);
        if (!err) begin
            check_instr("slot 0", o_instr0, mem_word(p));
            if (!p[2]) begin
                check_instr("slot 1", o_instr1, mem_word(p + 32'd4));
            end
        end
        p = next_pc(p);
    end
endtask

// one cycle of redirect with the consumer held off so nothing old slips through
task automatic steer_pc(input logic exc, input logic eret, input addr_t epc,
                        input logic br, input addr_t target);
    @(negedge clk);
    i_pair_ready    = 1'b0;
    i_exc           = exc;
    i_eret          = eret;
    i_epc           = epc;
    i_branch        = br;
    i_branch_target = target;
    @(negedge clk);
    i_exc    = 1'b0;
    i_eret   = 1'b0;
    i_branch = 1'b0;
endtask

// sequential pairs from the reset vector
task automatic stream_after_reset();
    // nothing requested or delivered straight out of reset
    check_flag("arvalid after reset", o_arvalid, 1'b0);
    check_flag("pair valid after reset", o_pair_valid, 1'b0);
    expect_pairs(RESET_PC, 8, 1'b0);
endtask

// random consumer stalls picking up where the reset stream stopped
task automatic stream_with_stalls();
    expect_pairs(RESET_PC + 32'd64, 24, 1'b1);
endtask

// bit 2 set gives one single-slot pair then aligned ones
task automatic branch_to_single();
    steer_pc(1'b0, 1'b0, '0, 1'b1, 32'h8000_0104);
    expect_pairs(32'h8000_0104, 6, 1'b1);
endtask

// exception beats eret beats branch
task automatic redirect_priority();
    steer_pc(1'b1, 1'b1, 32'h8000_2000, 1'b1, 32'h8000_3000);
    expect_pairs(EXC_VECTOR, 4, 1'b0);
    steer_pc(1'b0, 1'b1, 32'h8000_2000, 1'b1, 32'h8000_3000);
    expect_pairs(32'h8000_2000, 4, 1'b0);
endtask

// misaligned target gives one flagged pair and no bus request before the halt
task automatic misaligned_branch();
    addr_t target;
    int    log_mark;
    int    extra;
    target   = 32'h8000_4002;
    log_mark = ar_log.size();
    extra    = 0;
    steer_pc(1'b0, 1'b0, '0, 1'b1, target);
    take_pair(1'b0);
    check_addr("adel pc", o_pc, target);
    check_flag("adel flag", o_adel, 1'b1);
    check_flag("adel slot 1 valid", o_slot1_valid, 1'b0);
    check_instr("adel slot 0", o_instr0, '0);
    check_instr("adel slot 1", o_instr1, '0);
    check_flag("adel bus error", o_bus_err, 1'b0);
    // pc is parked so nothing else may show up
    repeat (QUIET_CYCLES) begin
        @(negedge clk);
        if (o_pair_valid) begin
            extra++;
        end
    end
    if (extra != 0) begin
        $display("pairs kept arriving for %0d cycles after the address error", extra);
        other_errors++;
    end
    // any request inside the target's 8-byte block counts, aligned or not
    for (int k = log_mark; k < ar_log.size(); k++) begin
        if (ar_log[k][31:3] == target[31:3]) begin
            $display("memory saw a read request for the misaligned fetch at %h", target);
            other_errors++;
        end
    end
    // a fresh branch gets fetch going again
    steer_pc(1'b0, 1'b0, '0, 1'b1, 32'h8000_5000);
    expect_pairs(32'h8000_5000, 4, 1'b0);
endtask

// slave error on one address is flagged on its pair while the stream goes on
task automatic bus_error_pair();
    bad_addr = 32'h8000_6010;
    steer_pc(1'b0, 1'b0, '0, 1'b1, 32'h8000_6000);
    expect_pairs(32'h8000_6000, 6, 1'b1);
    bad_addr = NO_BAD_ADDR;
endtask

`endif

// File: sim/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;
    import fetch_pkg::*;

    // dut configuration
    localparam addr_t       RESET_PC     = 32'hbfc0_0000;
    localparam addr_t       EXC_VECTOR   = 32'hbfc0_0380;
    localparam int          MAX_INFLIGHT = 2;
    localparam int          QUEUE_DEPTH  = 2;
    localparam int unsigned SEED         = 32'h10d3;
    // word at address a reads as a ^ key
    localparam addr_t       MEM_KEY      = 32'h5a5a_c3c3;
    // misaligned and never equal to a bus address
    localparam addr_t       NO_BAD_ADDR  = 32'hffff_ffff;
    localparam axi_resp_t   RESP_SLVERR  = 2'b10;
    // responder wait limits in cycles
    localparam int          AR_DELAY_MAX = 3;
    localparam int          R_DELAY_MAX  = 3;
    // cycle budget for every pair of every test at the slowest memory and consumer
    localparam int PAIR_COUNT        = 57;
    localparam int WORST_PAIR_CYCLES = 4 * (AR_DELAY_MAX + R_DELAY_MAX + 4);
    localparam int QUIET_CYCLES      = 40;
    localparam int TIMEOUT_CYCLES    = PAIR_COUNT * WORST_PAIR_CYCLES + QUIET_CYCLES + 200;

    logic      clk             = 1'b0;
    logic      reset           = 1'b1;
    logic      i_exc           = 1'b0;
    logic      i_eret          = 1'b0;
    addr_t     i_epc           = '0;
    logic      i_branch        = 1'b0;
    addr_t     i_branch_target = '0;
    logic      i_arready       = 1'b0;
    bus_data_t i_rdata         = '0;
    axi_resp_t i_rresp         = RESP_OKAY;
    logic      i_rvalid        = 1'b0;
    logic      i_pair_ready    = 1'b0;
    addr_t     o_araddr;
    logic      o_arvalid;
    logic      o_rready;
    logic      o_pair_valid;
    addr_t     o_pc;
    instr_t    o_instr0;
    instr_t    o_instr1;
    logic      o_slot1_valid;
    logic      o_adel;
    logic      o_bus_err;

    // responder state
    addr_t ar_pending[$];
    addr_t ar_log[$];
    addr_t r_addr;
    addr_t bad_addr    = NO_BAD_ADDR;
    int    ar_wait     = 0;
    int    r_wait      = 0;
    // scoreboard
    int    value_errors = 0;
    int    other_errors = 0;
    int    cycle_count  = 0;

    `include "tb_fetch_tests.svh"

    fetch_top #(
        .RESET_PC     (RESET_PC),
        .EXC_VECTOR   (EXC_VECTOR),
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .i_exc           (i_exc),
        .i_eret          (i_eret),
        .i_epc           (i_epc),
        .i_branch        (i_branch),
        .i_branch_target (i_branch_target),
        .o_araddr        (o_araddr),
        .o_arvalid       (o_arvalid),
        .i_arready       (i_arready),
        .i_rdata         (i_rdata),
        .i_rresp         (i_rresp),
        .i_rvalid        (i_rvalid),
        .o_rready        (o_rready),
        .i_pair_ready    (i_pair_ready),
        .o_pair_valid    (o_pair_valid),
        .o_pc            (o_pc),
        .o_instr0        (o_instr0),
        .o_instr1        (o_instr1),
        .o_slot1_valid   (o_slot1_valid),
        .o_adel          (o_adel),
        .o_bus_err       (o_bus_err)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // memory model decides at the falling edge what the next rising edge sees
    always @(negedge clk) begin
        i_rvalid = 1'b0;
        i_rdata  = '0;
        i_rresp  = RESP_OKAY;
        // the read channel is always open on the fetch side
        if (!reset) begin
            check_flag("rready", o_rready, 1'b1);
        end
        // r channel first so an address is never answered in its own ar cycle
        if (!reset && o_rready && ar_pending.size() > 0) begin
            if (r_wait == 0) begin
                r_addr   = ar_pending.pop_front();
                i_rvalid = 1'b1;
                i_rdata  = {mem_word(r_addr + 32'd4), mem_word(r_addr)};
                i_rresp  = (r_addr == bad_addr) ? RESP_SLVERR : RESP_OKAY;
                r_wait   = int'($urandom % (R_DELAY_MAX + 1));
            end else begin
                r_wait--;
            end
        end
        i_arready = 1'b0;
        if (!reset && o_arvalid) begin
            if (ar_wait == 0) begin
                // handshake lands on the coming rising edge
                i_arready = 1'b1;
                ar_pending.push_back(o_araddr);
                ar_log.push_back(o_araddr);
                ar_wait = int'($urandom % (AR_DELAY_MAX + 1));
            end else begin
                ar_wait--;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d value errors, %0d other errors",
                     cycle_count, value_errors, other_errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        stream_after_reset();
        stream_with_stalls();
        branch_to_single();
        redirect_priority();
        misaligned_branch();
        bus_error_pair();
        @(negedge clk);
        i_pair_ready = 1'b0;
        $display("run complete: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+sim
rtl/fetch_pkg.sv
rtl/pc_select.sv
rtl/ifetch_req.sv
rtl/fetch_split.sv
rtl/fetch_top.sv
sim/tb_fetch.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fetch -f flist.f -o tb_fetch \
    && ./obj_dir/tb_fetch > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }
cat sim.log
# the log decides, a fail report or a missing pass report is a failure
grep -q "Simulation finished: FAIL" sim.log && { echo "testbench reported failures"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no pass report in sim.log"; exit 1; }
echo "simulation passed"
